//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tb_circle
RTL_TOP    ?= circle_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing
RTL_INC    ?= +incdir+hw
RTL_SRCS   ?= hw/circle_pkg.sv hw/screen_clear.sv hw/circle_datapath.sv \
              hw/circle_fsm.sv hw/circle_top.sv

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(RTL_INC) $(RTL_SRCS) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation OK"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/circle_consts.svh
`ifndef CIRCLE_CONSTS_SVH
`define CIRCLE_CONSTS_SVH

// Visible screen area in pixels
`define SCREEN_W 160
`define SCREEN_H 120

// Pixel coordinate widths, enough for 0..159 and 0..119
`define X_DW 8
`define Y_DW 7

// Radius is an unsigned byte, so up to 255
`define RADIUS_DW 8

// Signed working width for centre +/- radius
// 255 + 255 = 510 still fits in 10 bits signed
`define COORD_DW 10

// Colour index width
`define COLOUR_DW 3

`endif

//--- hw/circle_datapath.sv
`timescale 1ns/1ps

`include "circle_consts.svh"

module circle_datapath (
    input  logic                    clk,
    input  logic                    resetn,
    input  circle_pkg::circle_req_t req,
    input  logic                    latch_req,
    input  circle_pkg::dp_ctrl_t    ctrl,
    output logic                    clear_last,
    output logic                    more,
    output circle_pkg::pixel_t      pixel,
    output logic                    plot
);

    // Criterion needs headroom beyond the coordinate range
    localparam int CRIT_DW = `COORD_DW + 2;

    circle_pkg::circle_req_t req_q;

    logic signed [`COORD_DW-1:0] offset_x;
    logic signed [`COORD_DW-1:0] offset_y;
    logic signed [CRIT_DW-1:0]   crit;

    logic signed [`COORD_DW-1:0] next_y;
    logic signed [`COORD_DW-1:0] next_x;

    logic signed [`COORD_DW-1:0] cx;
    logic signed [`COORD_DW-1:0] cy;
    logic signed [`COORD_DW-1:0] pt_x;
    logic signed [`COORD_DW-1:0] pt_y;
    logic                        on_screen;

    circle_pkg::pixel_t clear_pixel;
    logic               clear_plot;

    screen_clear u_clear (
        .clk    (clk),
        .resetn (resetn),
        .run    (ctrl.clear_run),
        .pixel  (clear_pixel),
        .plot   (clear_plot),
        .last   (clear_last)
    );

    // Request copy taken when the controller accepts start
    always_ff @(posedge clk) begin
        if (latch_req) begin
            req_q <= req;
        end
    end

    // Offsets after this step
    // x only moves once crit is positive
    assign next_y = offset_y + `COORD_DW'(1);
    assign next_x = (crit <= 0) ? offset_x : offset_x - `COORD_DW'(1);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            offset_x <= '0;
            offset_y <= '0;
            crit     <= '0;
        end else if (ctrl.load_init) begin
            offset_x <= $signed({2'b00, req_q.radius});
            offset_y <= '0;
            crit     <= CRIT_DW'(1) - $signed({4'b0000, req_q.radius});
        end else if (ctrl.step) begin
            offset_x <= next_x;
            offset_y <= next_y;
            if (crit <= 0) begin
                crit <= crit + CRIT_DW'(2 * next_y) + CRIT_DW'(1);
            end else begin
                crit <= crit + CRIT_DW'(2 * (next_y - next_x)) + CRIT_DW'(1);
            end
        end
    end

    assign more = (offset_y <= offset_x);

    // Centre widened to the signed working range
    assign cx = $signed({2'b00, req_q.centre_x});
    assign cy = $signed({3'b000, req_q.centre_y});

    // Mirror the octant step into all eight points
    always_comb begin
        case (ctrl.octant_sel)
            3'd0: begin
                pt_x = cx + offset_x;
                pt_y = cy + offset_y;
            end
            3'd1: begin
                pt_x = cx + offset_y;
                pt_y = cy + offset_x;
            end
            3'd2: begin
                pt_x = cx - offset_y;
                pt_y = cy + offset_x;
            end
            3'd3: begin
                pt_x = cx - offset_x;
                pt_y = cy + offset_y;
            end
            3'd4: begin
                pt_x = cx - offset_x;
                pt_y = cy - offset_y;
            end
            3'd5: begin
                pt_x = cx - offset_y;
                pt_y = cy - offset_x;
            end
            3'd6: begin
                pt_x = cx + offset_y;
                pt_y = cy - offset_x;
            end
            default: begin
                pt_x = cx + offset_x;
                pt_y = cy - offset_y;
            end
        endcase
    end

    // Clip against the visible area
    assign on_screen = (pt_x >= 0) && (pt_x < `COORD_DW'(`SCREEN_W)) &&
                       (pt_y >= 0) && (pt_y < `COORD_DW'(`SCREEN_H));

    // Clear scan owns the output while it runs
    always_comb begin
        if (ctrl.clear_run) begin
            pixel = clear_pixel;
            plot  = clear_plot;
        end else begin
            pixel.x      = pt_x[`X_DW-1:0];
            pixel.y      = pt_y[`Y_DW-1:0];
            pixel.colour = req_q.colour;
            plot         = ctrl.plot_en && on_screen;
        end
    end

endmodule

//--- hw/circle_fsm.sv
`timescale 1ns/1ps

module circle_fsm (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 start,
    input  logic                 more,
    input  logic                 clear_last,
    output circle_pkg::dp_ctrl_t ctrl,
    output logic                 latch_req,
    output logic                 done
);

    typedef enum logic [2:0] {
        s_idle,
        s_clear,
        s_init,
        s_plot,
        s_step,
        s_finish
    } state_t;

    state_t     state;
    state_t     state_next;
    logic [2:0] oct_cnt;

    // Request is taken on the cycle start is seen in idle
    assign latch_req = (state == s_idle) && start;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= s_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            s_idle: begin
                if (start) begin
                    state_next = s_clear;
                end
            end
            s_clear: begin
                if (clear_last) begin
                    state_next = s_init;
                end
            end
            s_init: begin
                state_next = s_plot;
            end
            s_plot: begin
                // more is checked on entry, the offsets hold through all eight points
                if (!more) begin
                    state_next = s_finish;
                end else if (oct_cnt == 3'd7) begin
                    state_next = s_step;
                end
            end
            s_step: begin
                state_next = s_plot;
            end
            s_finish: begin
                if (!start) begin
                    state_next = s_idle;
                end
            end
            default: begin
                state_next = s_idle;
            end
        endcase
    end

    // Octant index walks 0..7 and wraps back for the next step
    always_ff @(posedge clk) begin
        if (!resetn) begin
            oct_cnt <= '0;
        end else if (state == s_plot && more) begin
            oct_cnt <= oct_cnt + 1'b1;
        end else begin
            oct_cnt <= '0;
        end
    end

    always_comb begin
        ctrl.clear_run  = (state == s_clear);
        ctrl.load_init  = (state == s_init);
        ctrl.step       = (state == s_step);
        ctrl.octant_sel = oct_cnt;
        ctrl.plot_en    = (state == s_plot) && more;
    end

    assign done = (state == s_finish);

endmodule

//--- hw/circle_pkg.sv
package circle_pkg;

`include "circle_consts.svh"

    // One drawing request, held for the whole drawing
    typedef struct packed {
        logic [`X_DW-1:0]      centre_x;
        logic [`Y_DW-1:0]      centre_y;
        logic [`RADIUS_DW-1:0] radius;
        logic [`COLOUR_DW-1:0] colour;
    } circle_req_t;

    // Pixel handed to the screen sink
    typedef struct packed {
        logic [`X_DW-1:0]      x;
        logic [`Y_DW-1:0]      y;
        logic [`COLOUR_DW-1:0] colour;
    } pixel_t;

    // Commands from the controller to the datapath
    typedef struct packed {
        logic       clear_run;
        logic       load_init;
        logic       step;
        // Which of the eight mirrored points is shown
        logic [2:0] octant_sel;
        logic       plot_en;
    } dp_ctrl_t;

endpackage

//--- hw/circle_top.sv
`timescale 1ns/1ps

module circle_top (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    start,
    input  circle_pkg::circle_req_t req,
    output logic                    done,
    output circle_pkg::pixel_t      pixel,
    output logic                    plot
);

    circle_pkg::dp_ctrl_t ctrl;
    logic                 latch_req;
    logic                 more;
    logic                 clear_last;

    circle_fsm u_fsm (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .more       (more),
        .clear_last (clear_last),
        .ctrl       (ctrl),
        .latch_req  (latch_req),
        .done       (done)
    );

    circle_datapath u_dp (
        .clk        (clk),
        .resetn     (resetn),
        .req        (req),
        .latch_req  (latch_req),
        .ctrl       (ctrl),
        .clear_last (clear_last),
        .more       (more),
        .pixel      (pixel),
        .plot       (plot)
    );

endmodule

//--- hw/screen_clear.sv
`timescale 1ns/1ps

`include "circle_consts.svh"

module screen_clear (
    input  logic                clk,
    input  logic                resetn,
    input  logic                run,
    output circle_pkg::pixel_t  pixel,
    output logic                plot,
    output logic                last
);

    logic [`X_DW-1:0] x_cnt;
    logic [`Y_DW-1:0] y_cnt;
    logic             y_wrap;

    assign y_wrap = (y_cnt == `Y_DW'(`SCREEN_H - 1));

    // Column by column, y is the fast index
    always_ff @(posedge clk) begin
        if (!resetn) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (!run) begin
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (y_wrap) begin
            y_cnt <= '0;
            x_cnt <= x_cnt + 1'b1;
        end else begin
            y_cnt <= y_cnt + 1'b1;
        end
    end

    // Every scanned position is painted black
    always_comb begin
        pixel.x      = x_cnt;
        pixel.y      = y_cnt;
        pixel.colour = '0;
    end

    assign plot = run;

    // Bottom right corner closes the scan
    assign last = run && y_wrap && (x_cnt == `X_DW'(`SCREEN_W - 1));

endmodule

//--- tb.f
+incdir+hw
hw/circle_pkg.sv
hw/screen_clear.sv
hw/circle_datapath.sv
hw/circle_fsm.sv
hw/circle_top.sv
verif/clk_gen.sv
verif/tb_circle.sv

//--- verif/clk_gen.sv
`timescale 1ns/1ps

module clk_gen #(
    parameter int HALF_PERIOD_NS = 20
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
    end

    always begin
        #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

//--- verif/tb_circle.sv
`timescale 1ns/1ps

`include "circle_consts.svh"

module tb_circle;

    localparam int NUM_TESTS      = 17;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 30000;
    localparam int NUM_POS        = `SCREEN_W * `SCREEN_H;

    logic                    clk;
    logic                    resetn;
    logic                    start;
    circle_pkg::circle_req_t req_in;
    logic                    done;
    circle_pkg::pixel_t      pixel;
    logic                    plot;

    // Screen as seen by the sink and the screen the circle rule predicts
    logic [`COLOUR_DW-1:0] model_screen [0:NUM_POS-1];
    logic [`COLOUR_DW-1:0] exp_screen [0:NUM_POS-1];

    int   plot_count;
    int   exp_count;
    int   error_count;
    int   cycle_cnt = 0;
    logic compare_go;

    clk_gen #(.HALF_PERIOD_NS(20)) u_clk (
        .clk (clk)
    );

    circle_top dut0 (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .req    (req_in),
        .done   (done),
        .pixel  (pixel),
        .plot   (plot)
    );

    function automatic logic [14:0] pos_index(input int x, input int y);
        return 15'(x * `SCREEN_H + y);
    endfunction

    task automatic check_value(input int got, input int expected, input string what);
        if (got != expected) begin
            error_count++;
            $display("FAIL at %0t ns: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Test failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // Leftover junk so that a missing clear shows up
    function automatic void fill_screen();
        int x;
        int y;
        for (x = 0; x < `SCREEN_W; x++) begin
            for (y = 0; y < `SCREEN_H; y++) begin
                model_screen[pos_index(x, y)] = `COLOUR_DW'(((x * 3) + (y * 5)) % 7 + 1);
            end
        end
    endfunction

    // Expected screen after one drawing
    // Returns the number of plot strobes
    function automatic int build_expected(input circle_pkg::circle_req_t r);
        int x;
        int y;
        int ox;
        int oy;
        int crit;
        int k;
        int a;
        int b;
        int px;
        int py;
        int count;
        for (x = 0; x < `SCREEN_W; x++) begin
            for (y = 0; y < `SCREEN_H; y++) begin
                exp_screen[pos_index(x, y)] = '0;
            end
        end
        count = NUM_POS;
        ox    = int'(r.radius);
        oy    = 0;
        crit  = 1 - int'(r.radius);
        while (oy <= ox) begin
            for (k = 0; k < 8; k++) begin
                // Bit 2 swaps the offsets and bits 0 and 1 pick the signs
                a  = (k & 4) != 0 ? oy : ox;
                b  = (k & 4) != 0 ? ox : oy;
                px = int'(r.centre_x) + ((k & 1) != 0 ? -a : a);
                py = int'(r.centre_y) + ((k & 2) != 0 ? -b : b);
                if (px >= 0 && px < `SCREEN_W && py >= 0 && py < `SCREEN_H) begin
                    exp_screen[pos_index(px, py)] = r.colour;
                    count++;
                end
            end
            oy++;
            if (crit <= 0) begin
                crit = crit + 2 * oy + 1;
            end else begin
                ox--;
                crit = crit + 2 * (oy - ox) + 1;
            end
        end
        return count;
    endfunction

    function automatic circle_pkg::circle_req_t make_req(input int x, input int y,
                                                         input int rad, input int col);
        circle_pkg::circle_req_t r;
        r.centre_x = `X_DW'(x);
        r.centre_y = `Y_DW'(y);
        r.radius   = `RADIUS_DW'(rad);
        r.colour   = `COLOUR_DW'(col);
        return r;
    endfunction

    // One full drawing with start kept high for hold cycles after done
    task automatic draw_circle(input circle_pkg::circle_req_t r, input int hold);
        int k;
        @(negedge clk);
        exp_count  = build_expected(r);
        plot_count = 0;
        req_in     = r;
        start      = 1'b1;
        @(negedge clk);
        // Request is latched by now
        req_in = circle_pkg::circle_req_t'(~r);
        while (!done) begin
            @(negedge clk);
        end
        for (k = 0; k < hold; k++) begin
            @(negedge clk);
            check_value(int'(done), 1, "done while start held");
            check_value(int'(plot), 0, "plot after done");
        end
        start = 1'b0;
        @(negedge clk);
        check_value(int'(done), 0, "done after start low");
        compare_go = 1'b1;
        wait (!compare_go);
    endtask

    // Sink side that takes every strobed pixel
    always @(posedge clk) begin
        if (resetn && plot) begin
            if (int'(pixel.x) >= `SCREEN_W || int'(pixel.y) >= `SCREEN_H) begin
                $display("Plot strobed for off-screen point x=%0d y=%0d at %0t ns",
                         pixel.x, pixel.y, $time);
                $display("Test failed");
                $fatal(1, "pixel outside the screen");
            end else begin
                model_screen[pos_index(int'(pixel.x), int'(pixel.y))] = pixel.colour;
                plot_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // Screen comparison after each drawing
    initial begin
        int x;
        int y;
        forever begin
            wait (compare_go);
            for (x = 0; x < `SCREEN_W; x++) begin
                for (y = 0; y < `SCREEN_H; y++) begin
                    check_value(int'(model_screen[pos_index(x, y)]),
                                int'(exp_screen[pos_index(x, y)]),
                                $sformatf("colour at x=%0d y=%0d", x, y));
                end
            end
            check_value(plot_count, exp_count, "number of plot strobes");
            compare_go = 1'b0;
        end
    end

    initial begin
        circle_pkg::circle_req_t r;
        int i;
        int hold;
        error_count = 0;
        compare_go  = 1'b0;
        plot_count  = 0;
        exp_count   = 0;
        resetn      = 1'b0;
        start       = 1'b0;
        req_in      = '0;
        void'($urandom(82));
        fill_screen();
        repeat (16) @(negedge clk);
        resetn = 1'b1;

        // Quiet outputs in idle
        repeat (8) begin
            @(negedge clk);
            check_value(int'(plot), 0, "plot in idle");
            check_value(int'(done), 0, "done in idle");
        end

        draw_circle(make_req(80, 60, 40, 5), 3);

        // Corners and edges with some radii far past the screen
        draw_circle(make_req(0, 0, 30, 3), 1);
        draw_circle(make_req(159, 119, 50, 6), 2);
        draw_circle(make_req(5, 60, 255, 2), 1);
        draw_circle(make_req(80, 0, 100, 4), 4);
        draw_circle(make_req(159, 10, 200, 1), 1);

        // Single dot that must replace everything drawn before
        draw_circle(make_req(20, 100, 0, 7), 2);

        for (i = 0; i < 10; i++) begin
            r.centre_x = `X_DW'($urandom_range(0, `SCREEN_W - 1));
            r.centre_y = `Y_DW'($urandom_range(0, `SCREEN_H - 1));
            r.radius   = `RADIUS_DW'($urandom_range(0, 255));
            r.colour   = `COLOUR_DW'($urandom_range(1, 7));
            hold       = int'($urandom_range(1, 6));
            draw_circle(r, hold);
        end

        if (error_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "errors found");
        end
    end

endmodule
